//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_mem_hier
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
SIM_ARGS  ?= +verilator+error+limit+1000

SOURCES := $(shell grep -v '^+' filelist.f)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): filelist.f $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f filelist.f

run: compile
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- filelist.f
rtl/lc3b_types.sv
rtl/cache_pkg.sv
rtl/l1_cache_control.sv
rtl/l1_cache.sv
rtl/arbiter.sv
rtl/mem_hier.sv
verif/mem_hier_properties.sv
verif/tb_mem_hier.sv

//--- rtl/arbiter.sv
module arbiter (
    input  logic                  clk,
    input  logic                  i_arst_n,
    input  lc3b_types::pmem_req_t i_ipmem_req,   // Instruction cache line request.
    input  lc3b_types::pmem_req_t i_dpmem_req,   // Data cache line request.
    input  logic                  i_mem_resp,    // Memory finished the granted transfer.
    output logic                  o_ipmem_resp,  // Response steered to the instruction cache.
    output logic                  o_dpmem_resp,  // Response steered to the data cache.
    output lc3b_types::pmem_req_t o_mem_req      // Granted request toward memory.
);
    import lc3b_types::*;
    import cache_pkg::*;

    arb_state_e state_q;
    arb_state_e state_d;
    logic       ipend;    // Instruction side wants memory.
    logic       dpend;    // Data side wants memory.
    pmem_req_t  sel_req;  // Request of the current owner.

    assign ipend = i_ipmem_req.read | i_ipmem_req.write;
    assign dpend = i_dpmem_req.read | i_dpmem_req.write;

    always_comb begin
        state_d = state_q;
        case (state_q)
            arb_idle: begin
                if (dpend) begin
                    state_d = arb_dcache;  // Data side wins a tie.
                end else if (ipend) begin
                    state_d = arb_icache;
                end
            end
            arb_icache, arb_dcache: begin
                if (i_mem_resp) begin
                    state_d = arb_idle;  // One quiet cycle before the next grant.
                end
            end
            default: begin
                state_d = arb_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= arb_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign sel_req = (state_q == arb_dcache) ? i_dpmem_req : i_ipmem_req;

    // Memory sees nothing while the arbiter is idle.
    assign o_mem_req = (state_q == arb_idle) ? '0 : sel_req;

    // Only the owner hears the response.
    assign o_ipmem_resp = (state_q == arb_icache) & i_mem_resp;
    assign o_dpmem_resp = (state_q == arb_dcache) & i_mem_resp;

endmodule : arbiter

//--- rtl/cache_pkg.sv
package cache_pkg;

    localparam int NUM_SETS    = 8;  // Sets in each way.
    localparam int NUM_WAYS    = 2;  // Two-way set associative.
    localparam int OFFSET_BITS = 4;  // Byte offset inside a 16-byte line.
    localparam int INDEX_BITS  = 3;  // Picks one of the eight sets.
    localparam int TAG_BITS    = 9;  // Upper address bits kept per line.

    // Split of a 16-bit byte address as the cache sees it.
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;     // Compared against both ways.
        logic [INDEX_BITS-1:0]  index;   // Selects the set.
        logic [OFFSET_BITS-1:0] offset;  // Byte within the line.
    } cache_addr_t;

    // Cache controller states.
    typedef enum logic [1:0] {
        idle_hit   = 2'd0,  // Waits for a request and answers hits.
        write_back = 2'd1,  // Stores the dirty victim line.
        allocate   = 2'd2   // Fetches the missing line.
    } cache_state_e;

    // Arbiter states.
    typedef enum logic [1:0] {
        arb_idle   = 2'd0,  // No owner this cycle.
        arb_icache = 2'd1,  // Instruction cache owns memory.
        arb_dcache = 2'd2   // Data cache owns memory.
    } arb_state_e;

endpackage : cache_pkg

//--- rtl/l1_cache.sv
module l1_cache (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  lc3b_types::mem_req_t     i_req,         // Core request, held until o_resp.
    input  logic                     i_pmem_resp,   // Line transfer done.
    input  lc3b_types::lc3b_mem_data i_pmem_rdata,  // Line returned by memory.
    output logic                     o_resp,        // Pulses once per request.
    output lc3b_types::lc3b_word     o_rdata,       // Valid while o_resp is high.
    output lc3b_types::pmem_req_t    o_pmem_req     // Request toward the arbiter.
);
    import lc3b_types::*;
    import cache_pkg::*;

    // Storage arrays, indexed by way then set.
    logic [TAG_BITS-1:0]               tag_q  [NUM_WAYS][NUM_SETS];
    lc3b_mem_data                      data_q [NUM_WAYS][NUM_SETS];
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] valid_q;  // Line holds memory contents.
    logic [NUM_WAYS-1:0][NUM_SETS-1:0] dirty_q;  // Line differs from memory.
    logic [NUM_SETS-1:0]               lru_q;    // Points at the least recently used way.

    cache_addr_t         addr;          // Current request address split up.
    logic [2:0]          word_sel;      // Word within the line.
    logic [NUM_WAYS-1:0] way_hit;       // Per-way tag match.
    logic                hit;
    logic                hit_way;       // Way that matched.
    logic                victim_way;    // Way to replace on a miss.
    logic                dirty_victim;
    lc3b_mem_data        hit_line;
    lc3b_mem_data        victim_line;
    lc3b_mem_data        merged_line;   // Hit line with the write word merged in.
    lc3b_word            hit_word;
    logic                pmem_read;
    logic                pmem_write;
    logic                load_line;
    logic                set_dirty;
    logic                update_lru;

    assign addr     = cache_addr_t'(i_req.addr);
    assign word_sel = addr.offset[OFFSET_BITS-1:1];  // Byte bit 0 is dropped.

    // Both ways are compared at once.
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            way_hit[w] = valid_q[w][addr.index] && (tag_q[w][addr.index] == addr.tag);
        end
    end

    assign hit          = |way_hit;
    assign hit_way      = way_hit[1];          // Way 0 unless way 1 matched.
    assign victim_way   = lru_q[addr.index];   // LRU way gets replaced.
    assign dirty_victim = valid_q[victim_way][addr.index] & dirty_q[victim_way][addr.index];
    assign hit_line     = data_q[hit_way][addr.index];
    assign victim_line  = data_q[victim_way][addr.index];
    assign hit_word     = hit_line[{word_sel, 4'd0} +: 16];

    // Byte-masked merge of the write word into its slot.
    always_comb begin
        merged_line = hit_line;
        if (i_req.wmask[0]) begin
            merged_line[{word_sel, 4'd0} +: 8] = i_req.wdata[7:0];   // Low byte.
        end
        if (i_req.wmask[1]) begin
            merged_line[{word_sel, 4'd8} +: 8] = i_req.wdata[15:8];  // High byte.
        end
    end

    // Payload storage and the read data register.
    always_ff @(posedge clk) begin
        if (load_line) begin
            data_q[victim_way][addr.index] <= i_pmem_rdata;  // Fill replaces the victim.
            tag_q[victim_way][addr.index]  <= addr.tag;
        end else if (set_dirty) begin
            data_q[hit_way][addr.index] <= merged_line;
        end
        if (update_lru) begin
            o_rdata <= hit_word;  // Presented together with o_resp.
        end
    end

    // Line state bits.
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
            lru_q   <= '0;
        end else begin
            if (load_line) begin
                valid_q[victim_way][addr.index] <= 1'b1;
                dirty_q[victim_way][addr.index] <= 1'b0;  // Fresh line matches memory.
            end
            if (set_dirty) begin
                dirty_q[hit_way][addr.index] <= 1'b1;
            end
            if (update_lru) begin
                lru_q[addr.index] <= ~hit_way;  // The other way is now the older one.
            end
        end
    end

    // Write-back uses the victim's stored tag, a fill uses the request tag.
    always_comb begin
        o_pmem_req.read  = pmem_read;
        o_pmem_req.write = pmem_write;
        o_pmem_req.wdata = victim_line;
        if (pmem_write) begin
            o_pmem_req.addr = {tag_q[victim_way][addr.index], addr.index, {OFFSET_BITS{1'b0}}};
        end else begin
            o_pmem_req.addr = {addr.tag, addr.index, {OFFSET_BITS{1'b0}}};
        end
    end

    l1_cache_control control (
        .clk           (clk),
        .i_arst_n      (i_arst_n),
        .i_read        (i_req.read),
        .i_write       (i_req.write),
        .i_hit         (hit),
        .i_dirty_victim(dirty_victim),
        .i_pmem_resp   (i_pmem_resp),
        .o_resp        (o_resp),
        .o_pmem_read   (pmem_read),
        .o_pmem_write  (pmem_write),
        .o_load_line   (load_line),
        .o_set_dirty   (set_dirty),
        .o_update_lru  (update_lru)
    );

endmodule : l1_cache

//--- rtl/l1_cache_control.sv
module l1_cache_control (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_read,          // Core read request level.
    input  logic i_write,         // Core write request level.
    input  logic i_hit,           // Tag match in either way.
    input  logic i_dirty_victim,  // Victim way holds modified data.
    input  logic i_pmem_resp,     // Memory finished the current line transfer.
    output logic o_resp,          // One-cycle answer to the core.
    output logic o_pmem_read,     // Line fetch request.
    output logic o_pmem_write,    // Victim store request.
    output logic o_load_line,     // Write the fetched line into the victim way.
    output logic o_set_dirty,     // Merge the write word into the hit line.
    output logic o_update_lru     // Mark the hit way as most recently used.
);
    import cache_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;
    logic         resp_q;   // Registered answer, high for exactly one cycle.
    logic         req_new;  // A request that has not been answered yet.

    // The request is still held in the cycle o_resp is high, so it is ignored there.
    assign req_new = (i_read | i_write) & ~resp_q;

    always_comb begin
        state_d      = state_q;  // Stay put unless something below moves us.
        o_pmem_read  = 1'b0;
        o_pmem_write = 1'b0;
        o_load_line  = 1'b0;
        o_set_dirty  = 1'b0;
        o_update_lru = 1'b0;
        case (state_q)
            idle_hit: begin
                if (req_new) begin
                    if (i_hit) begin
                        o_update_lru = 1'b1;     // Also arms the response register.
                        o_set_dirty  = i_write;  // Write hits modify the line.
                    end else if (i_dirty_victim) begin
                        state_d = write_back;    // Victim must reach memory first.
                    end else begin
                        state_d = allocate;      // Clean or invalid victim is overwritten.
                    end
                end
            end
            write_back: begin
                o_pmem_write = 1'b1;  // Held until memory acknowledges.
                if (i_pmem_resp) begin
                    state_d = allocate;
                end
            end
            allocate: begin
                o_pmem_read = 1'b1;         // Held until the line arrives.
                o_load_line = i_pmem_resp;  // Capture the line on the response beat.
                if (i_pmem_resp) begin
                    state_d = idle_hit;     // The request hits on the next cycle.
                end
            end
            default: begin
                state_d = idle_hit;
            end
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= idle_hit;
            resp_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            resp_q  <= o_update_lru;  // Answer lands one cycle after the hit is seen.
        end
    end

    assign o_resp = resp_q;

endmodule : l1_cache_control

//--- rtl/lc3b_types.sv
package lc3b_types;

    typedef logic [15:0]  lc3b_word;       // Data word and byte address.
    typedef logic [1:0]   lc3b_mem_wmask;  // Bit 0 enables the low byte, bit 1 the high byte.
    typedef logic [127:0] lc3b_mem_data;   // One 16-byte cache line.

    // Request from a core to an L1 cache, held until the cache answers.
    typedef struct packed {
        logic          read;   // Read the addressed word.
        logic          write;  // Write the addressed word under wmask.
        lc3b_mem_wmask wmask;  // Byte enables for a write.
        lc3b_word      addr;   // Byte address, bit 0 ignored for word access.
        lc3b_word      wdata;  // Word to write.
    } mem_req_t;

    // Line request toward physical memory.
    typedef struct packed {
        logic         read;    // Fetch one line.
        logic         write;   // Store one line.
        lc3b_word     addr;    // Line-aligned byte address.
        lc3b_mem_data wdata;   // Line to store.
    } pmem_req_t;

endpackage : lc3b_types

//--- rtl/mem_hier.sv
module mem_hier (
    input  logic                     clk,
    input  logic                     i_arst_n,
    input  lc3b_types::mem_req_t     i_ireq,        // Instruction fetch request.
    input  lc3b_types::mem_req_t     i_dreq,        // Data load or store request.
    input  logic                     i_pmem_resp,   // Physical memory done.
    input  lc3b_types::lc3b_mem_data i_pmem_rdata,  // Line from physical memory.
    output logic                     o_iresp,
    output lc3b_types::lc3b_word     o_irdata,
    output logic                     o_dresp,
    output lc3b_types::lc3b_word     o_drdata,
    output lc3b_types::pmem_req_t    o_pmem_req     // Shared physical memory port.
);
    import lc3b_types::*;

    pmem_req_t ipmem_req;   // Instruction cache toward the arbiter.
    pmem_req_t dpmem_req;   // Data cache toward the arbiter.
    logic      ipmem_resp;
    logic      dpmem_resp;

    // Both caches see the memory line directly.
    l1_cache i_cache (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_req       (i_ireq),
        .i_pmem_resp (ipmem_resp),
        .i_pmem_rdata(i_pmem_rdata),
        .o_resp      (o_iresp),
        .o_rdata     (o_irdata),
        .o_pmem_req  (ipmem_req)
    );

    l1_cache d_cache (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_req       (i_dreq),
        .i_pmem_resp (dpmem_resp),
        .i_pmem_rdata(i_pmem_rdata),
        .o_resp      (o_dresp),
        .o_rdata     (o_drdata),
        .o_pmem_req  (dpmem_req)
    );

    arbiter arbiter (
        .clk         (clk),
        .i_arst_n    (i_arst_n),
        .i_ipmem_req (ipmem_req),
        .i_dpmem_req (dpmem_req),
        .i_mem_resp  (i_pmem_resp),
        .o_ipmem_resp(ipmem_resp),
        .o_dpmem_resp(dpmem_resp),
        .o_mem_req   (o_pmem_req)
    );

endmodule : mem_hier

//--- verif/mem_hier_properties.sv
module mem_hier_properties #(
    parameter logic [31:0] SEED = 32'he656_97a5  // Seed of the initial memory image.
) (
    input logic                  clk,
    input logic                  i_arst_n,
    input lc3b_types::mem_req_t  i_ireq,
    input lc3b_types::mem_req_t  i_dreq,
    input logic                  i_iresp,
    input logic                  i_dresp,
    input lc3b_types::lc3b_word  i_irdata,
    input lc3b_types::lc3b_word  i_drdata,
    input lc3b_types::pmem_req_t i_ipmem_req,  // Instruction cache toward the arbiter.
    input lc3b_types::pmem_req_t i_dpmem_req,  // Data cache toward the arbiter.
    input lc3b_types::pmem_req_t i_pmem_req    // Shared memory port.
);
    timeunit 1ns;
    timeprecision 100ps;
    import lc3b_types::*;

    mem_req_t [1:0] req;          // Side 0 fetches instructions, side 1 loads and stores.
    pmem_req_t [1:0] side_pmem;   // Line request of each side's cache.
    logic     [1:0] resp;
    lc3b_word [1:0] rdata;
    lc3b_word [1:0] expect_w;     // Shadow word at each side's address.
    logic     [1:0] active;       // Request level per side.
    logic     [1:0] start;        // First cycle of a new request.
    logic     [1:0] pend_q;       // Request seen and not yet answered.
    logic     [1:0] last_read_q;  // Last completed access on the side was a read.
    lc3b_word [1:0] last_addr_q;
    logic [1:0][6:0] wait_q;      // Cycles the open request has waited.
    logic           seen_req_q;   // Any request since reset.
    lc3b_word       shadow [32768];  // What a core should read at each word.
    int             fail_count = 0;

    function automatic lc3b_word image_word(input lc3b_word addr);
        logic [31:0] x;
        x = ({16'h0, addr} * 32'h9e37_79b1) ^ SEED;  // Mixes every address bit.
        x = x ^ (x >> 15);
        x = x * 32'h85eb_ca6b;
        return x[31:16] ^ x[15:0];
    endfunction

    initial begin
        for (int w = 0; w < 32768; w++) begin
            shadow[w] = image_word(16'(w * 2));  // Same image the memory model starts from.
        end
    end

    assign req         = {i_dreq, i_ireq};
    assign side_pmem   = {i_dpmem_req, i_ipmem_req};
    assign resp        = {i_dresp, i_iresp};
    assign rdata       = {i_drdata, i_irdata};
    assign expect_w[0] = shadow[i_ireq.addr[15:1]];
    assign expect_w[1] = shadow[i_dreq.addr[15:1]];
    assign active      = {i_dreq.read | i_dreq.write, i_ireq.read | i_ireq.write};
    assign start       = active & ~pend_q;

    // Completed stores land in the shadow under their byte enables.
    always @(posedge clk) begin
        if (i_dresp && i_dreq.write) begin
            if (i_dreq.wmask[0]) begin
                shadow[i_dreq.addr[15:1]][7:0] <= i_dreq.wdata[7:0];
            end
            if (i_dreq.wmask[1]) begin
                shadow[i_dreq.addr[15:1]][15:8] <= i_dreq.wdata[15:8];
            end
        end
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pend_q      <= '0;
            last_read_q <= '0;
            last_addr_q <= '0;
            wait_q      <= '0;
            seen_req_q  <= 1'b0;
        end else begin
            seen_req_q <= seen_req_q | (|active);
            for (int s = 0; s < 2; s++) begin
                pend_q[s] <= active[s] & ~resp[s];
                wait_q[s] <= (active[s] && !resp[s]) ? wait_q[s] + 7'd1 : 7'd0;
                if (resp[s]) begin
                    last_read_q[s] <= req[s].read;  // Remembered for the hit latency check.
                    last_addr_q[s] <= req[s].addr;
                end
            end
        end
    end

    for (genvar s = 0; s < 2; s++) begin : g_side
        read_value_a: assert property (@(posedge clk) disable iff (!i_arst_n)
            resp[s] && req[s].read |-> rdata[s] == expect_w[s])
            else begin
                $error("mismatch at %0t: side %0d read of %h returned %h, expected %h", $time,
                       s, $sampled(req[s].addr), $sampled(rdata[s]), $sampled(expect_w[s]));
                fail_count++;
            end
        hit_latency_a: assert property (@(posedge clk) disable iff (!i_arst_n)
            start[s] && req[s].read && last_read_q[s] && req[s].addr == last_addr_q[s]
            |=> resp[s])
            else begin
                $error("side %0d repeated read was not answered one cycle later", s);
                fail_count++;
            end
        resp_deadline_a: assert property (@(posedge clk) disable iff (!i_arst_n)
            wait_q[s] <= 7'd64)
            else begin
                $error("side %0d request waited more than 64 cycles for its response", s);
                fail_count++;
            end
        // A fill fetches the aligned line of the open request. A write-back stores
        // another line of the same set.
        line_addr_a: assert property (@(posedge clk) disable iff (!i_arst_n)
            (side_pmem[s].read -> side_pmem[s].addr == {req[s].addr[15:4], 4'h0}) &&
            (side_pmem[s].write -> side_pmem[s].addr[6:0] == {req[s].addr[6:4], 4'h0} &&
                                   side_pmem[s].addr[15:4] != req[s].addr[15:4]))
            else begin
                $error("mismatch at %0t: side %0d memory request at %h for core address %h",
                       $time, s, $sampled(side_pmem[s].addr), $sampled(req[s].addr));
                fail_count++;
            end
    end

    no_overlap_a: assert property (@(posedge clk) disable iff (!i_arst_n)
        !(i_pmem_req.read && i_pmem_req.write))
        else begin
            $error("memory port shows read and write at the same time");
            fail_count++;
        end
    quiet_after_reset_a: assert property (@(posedge clk) disable iff (!i_arst_n)
        !seen_req_q |-> !(|resp || i_pmem_req.read || i_pmem_req.write))
        else begin
            $error("response or memory request seen before the first core request");
            fail_count++;
        end

endmodule : mem_hier_properties

bind mem_hier mem_hier_properties props_i (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_ireq     (i_ireq),
    .i_dreq     (i_dreq),
    .i_iresp    (o_iresp),
    .i_dresp    (o_dresp),
    .i_irdata   (o_irdata),
    .i_drdata   (o_drdata),
    .i_ipmem_req(ipmem_req),
    .i_dpmem_req(dpmem_req),
    .i_pmem_req (o_pmem_req)
);

//--- verif/tb_mem_hier.sv
module tb_mem_hier;
    timeunit 1ns;
    timeprecision 100ps;
    import lc3b_types::*;

    localparam logic [31:0] SEED     = 32'he656_97a5;
    localparam int          NUM_REQS = 172;  // Requests issued over all tests.

    logic         clk          = 1'b0;
    logic         arst_n       = 1'b0;
    mem_req_t     ireq         = '0;
    mem_req_t     dreq         = '0;
    logic         pmem_resp    = 1'b0;
    lc3b_mem_data pmem_rdata   = '0;
    logic         iresp;
    logic         dresp;
    lc3b_word     irdata;
    lc3b_word     drdata;
    pmem_req_t    pmem_req;
    logic [7:0]   pmem [65536];  // Byte-addressed physical memory, low byte at even address.
    int           req_count    = 0;
    int           test_count   = 0;
    int           fails_before = 0;

    always #20 clk = ~clk;

    mem_hier dut_i (
        .clk         (clk),
        .i_arst_n    (arst_n),
        .i_ireq      (ireq),
        .i_dreq      (dreq),
        .i_pmem_resp (pmem_resp),
        .i_pmem_rdata(pmem_rdata),
        .o_iresp     (iresp),
        .o_irdata    (irdata),
        .o_dresp     (dresp),
        .o_drdata    (drdata),
        .o_pmem_req  (pmem_req)
    );

    function automatic lc3b_word image_word(input lc3b_word addr);
        logic [31:0] x;
        x = ({16'h0, addr} * 32'h9e37_79b1) ^ SEED;  // Mixes every address bit.
        x = x ^ (x >> 15);
        x = x * 32'h85eb_ca6b;
        return x[31:16] ^ x[15:0];
    endfunction

    function automatic lc3b_word rand_addr(input lc3b_word base, input int span);
        return base + lc3b_word'($urandom_range(span - 1) & 32'hfffe);  // Even address.
    endfunction

    // Answers each line request after 1 to 6 cycles.
    always begin : memory_model
        lc3b_mem_data line;
        int           delay;
        @(posedge clk);
        if (pmem_req.read || pmem_req.write) begin
            delay = $urandom_range(6, 1);
            repeat (delay - 1) begin
                @(posedge clk);
            end
            for (int b = 0; b < 16; b++) begin
                if (pmem_req.write) begin
                    pmem[{pmem_req.addr[15:4], 4'(b)}] = pmem_req.wdata[8 * b +: 8];
                end
                line[8 * b +: 8] = pmem[{pmem_req.addr[15:4], 4'(b)}];
            end
            pmem_rdata <= line;
            pmem_resp  <= 1'b1;
            @(posedge clk);
            pmem_resp  <= 1'b0;  // The arbiter drops its grant on this edge.
        end
    end

    // Holds one request on a side until the cache answers.
    task automatic access(input bit side, input mem_req_t req);
        @(posedge clk);
        if (side) begin
            dreq <= req;
        end else begin
            ireq <= req;
        end
        do begin
            @(posedge clk);
        end while (!(side ? dresp : iresp));
        if (side) begin
            dreq <= '0;
        end else begin
            ireq <= '0;
        end
        req_count++;
    endtask

    task automatic read_word(input bit side, input lc3b_word addr);
        access(side, '{read: 1'b1, write: 1'b0, wmask: 2'b00, addr: addr, wdata: 16'h0});
    endtask

    task automatic write_word(input lc3b_word addr, input lc3b_mem_wmask mask,
                              input lc3b_word data);
        access(1'b1, '{read: 1'b0, write: 1'b1, wmask: mask, addr: addr, wdata: data});
    endtask

    task automatic finish_test(input string name);
        int fails;
        repeat (2) @(posedge clk);  // Lets the last assertions of the test settle.
        fails = dut_i.props_i.fail_count;
        test_count++;
        $display("[%0t] test %s done, %0d failures", $time, name, fails - fails_before);
        fails_before = fails;
    endtask

    initial begin : main
        lc3b_word a;
        int       fails;
        void'($urandom(SEED));
        for (int b = 0; b < 65536; b += 2) begin
            {pmem[b + 1], pmem[b]} = image_word(lc3b_word'(b));
        end
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        repeat (4) @(posedge clk);
        finish_test("reset");
        for (int k = 0; k < 8; k++) begin
            a = rand_addr(16'h4000, 4096);
            read_word(1'b1, a);  // Cold miss.
            read_word(1'b1, a);  // Same word again, a one-cycle hit.
            read_word(1'b0, lc3b_word'(k * 16));
            read_word(1'b0, lc3b_word'(k * 16));
        end
        finish_test("reads");
        for (int k = 0; k < 8; k++) begin
            a = rand_addr(16'h4000, 4096);
            write_word(a, k[0] ? 2'b10 : 2'b01, lc3b_word'($urandom));
            write_word(a + 16'd2, 2'b11, lc3b_word'($urandom));
            read_word(1'b1, a);
            read_word(1'b1, a + 16'd2);
        end
        finish_test("writes");
        // Three lines of set 0, so every round pushes dirty lines out to memory.
        for (int r = 0; r < 2; r++) begin
            for (int k = 0; k < 3; k++) begin
                write_word(lc3b_word'(16'h5000 + k * 128 + r * 2), 2'b11, lc3b_word'($urandom));
            end
            for (int k = 0; k < 3; k++) begin
                read_word(1'b1, lc3b_word'(16'h5000 + k * 128 + r * 2));
            end
        end
        finish_test("evictions");
        for (int k = 0; k < 8; k++) begin
            fork
                read_word(1'b0, lc3b_word'(16'h0800 + k * 64));
                write_word(lc3b_word'(16'h5000 + k * 256), 2'b11, lc3b_word'($urandom));
            join
        end
        finish_test("contention");
        // Fetches stay below 0x1000, where nothing is ever stored.
        for (int k = 0; k < 40; k++) begin
            fork
                read_word(1'b0, rand_addr(16'h0000, 4096));
                if ($urandom_range(1) == 1) begin
                    read_word(1'b1, rand_addr(16'h4000, 1024));
                end else begin
                    write_word(rand_addr(16'h4000, 1024), lc3b_mem_wmask'($urandom_range(3, 1)),
                               lc3b_word'($urandom));
                end
            join
        end
        finish_test("random");
        fails = dut_i.props_i.fail_count;
        $display("%0d tests, %0d requests, %0d failures", test_count, req_count, fails);
        if (fails == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (NUM_REQS * 200) @(posedge clk);
        $display("timeout: requests still unanswered after %0d cycles", NUM_REQS * 200);
        $display("TEST FAILED");
        $finish;
    end

endmodule : tb_mem_hier
